// ==== src.f ====
+incdir+.
icache_pkg.sv
icache_block.sv
icache_fill.sv
icache_read.sv
icache_top.sv
tb_clkgen.sv
tb_axi_mem.sv
tb_icache.sv

// ==== Makefile ====
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP ?= tb_icache
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx 'sim passed' $(LOG) || { echo "pass line not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_icache.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module tb_icache;
   import icache_pkg::*;

   localparam int REGION_WORDS = `ICACHE_BLOCKS * `ICACHE_WORDS;
   localparam int RAND_ENTRIES = 16;
   localparam int TBL_SIZE = REGION_WORDS + RAND_ENTRIES;
   localparam int RESET_TIMEOUT = 20;
   localparam int FILL_TIMEOUT = 5000;
   localparam logic [15:0] ERR_OFFSET = 16'h0024;

   logic clk;
   logic rst;
   logic fetch_req;
   fetch_addr_t fetch_addr;
   word_t fetch_data;
   logic fetch_valid;
   logic ready;
   logic fill_err;
   axil_ar_t ar;
   logic arready;
   axil_r_t r;
   logic rready;

   fetch_addr_t tbl_addr [TBL_SIZE];
   word_t tbl_exp [TBL_SIZE];

   int errors;
   int test_errors;
   int tests_run;
   int tests_failed;
   logic timed_out;

   tb_clkgen i_clkgen (.clk_o(clk), .rst_o(rst));

   icache_top i_dut (
      .clk_i(clk),
      .rst_i(rst),
      .fetch_req_i(fetch_req),
      .fetch_addr_i(fetch_addr),
      .fetch_data_o(fetch_data),
      .fetch_valid_o(fetch_valid),
      .ready_o(ready),
      .fill_err_o(fill_err),
      .m_ar_o(ar),
      .m_arready_i(arready),
      .m_r_i(r),
      .m_rready_o(rready)
   );

   tb_axi_mem i_mem (
      .clk_i(clk),
      .rst_i(rst),
      .ar_i(ar),
      .arready_o(arready),
      .r_o(r),
      .rready_i(rready)
   );

   // byte address times a fixed odd constant, then a fixed xor
   function automatic word_t expected_word(fetch_addr_t a);
      logic [31:0] byte_addr;
      byte_addr = 32'(`ICACHE_BASE_ADDR) + (32'(a) << 2);
      return (byte_addr * 32'h9e3779b1) ^ 32'h5a5a0000;
   endfunction

   task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("Error: %s is %h, expected %h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic end_test(string name);
      tests_run++;
      errors += test_errors;
      if (test_errors != 0) begin
         tests_failed++;
      end
      $display("test %0d, %s: %s, %0d errors", tests_run, name,
               (test_errors == 0) ? "ok" : "FAIL", test_errors);
      test_errors = 0;
   endtask

   task automatic build_table();
      // consecutive entries rotate through the blocks
      for (int i = 0; i < REGION_WORDS; i++) begin
         tbl_addr[i].index = index_t'(i % `ICACHE_BLOCKS);
         tbl_addr[i].offset = offset_t'(i / `ICACHE_BLOCKS);
      end
      for (int i = REGION_WORDS; i < TBL_SIZE; i++) begin
         tbl_addr[i].index = index_t'($urandom);
         tbl_addr[i].offset = offset_t'($urandom);
      end
      for (int i = 0; i < TBL_SIZE; i++) begin
         tbl_exp[i] = expected_word(tbl_addr[i]);
      end
   endtask

   task automatic wait_reset();
      int cycles;
      cycles = 0;
      while (rst !== 1'b0 && cycles < RESET_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (rst !== 1'b0) begin
         $display("Timeout: reset was still asserted after %0d cycles", RESET_TIMEOUT);
         timed_out = 1'b1;
      end
      @(negedge clk);
   endtask

   task automatic fill_test();
      int cycles;
      cycles = 0;
      compare_value("ready_o", 32'(ready), 32'h0);
      compare_value("fill_err_o", 32'(fill_err), 32'h0);
      // keep fetching during the fill and expect every request to be dropped
      while (!ready && cycles < FILL_TIMEOUT) begin
         compare_value("fetch_valid_o", 32'(fetch_valid), 32'h0);
         fetch_req = 1'b1;
         fetch_addr = tbl_addr[cycles % REGION_WORDS];
         @(negedge clk);
         cycles++;
      end
      fetch_req = 1'b0;
      if (!ready) begin
         $display("Timeout: ready_o did not rise within %0d cycles of the fill",
                  FILL_TIMEOUT);
         timed_out = 1'b1;
         test_errors++;
      end else begin
         repeat (3) begin
            compare_value("fetch_valid_o", 32'(fetch_valid), 32'h0);
            @(negedge clk);
         end
      end
      end_test("fetches dropped during the fill");
   endtask

   // one request and exactly two cycles to the response
   task automatic fetch_once(fetch_addr_t a, word_t exp);
      fetch_req = 1'b1;
      fetch_addr = a;
      @(negedge clk);
      fetch_req = 1'b0;
      compare_value("fetch_valid_o", 32'(fetch_valid), 32'h0);
      @(negedge clk);
      compare_value("fetch_valid_o", 32'(fetch_valid), 32'h1);
      compare_value("fetch_data_o", fetch_data, exp);
   endtask

   task automatic stream_test(string name, int first, int count);
      for (int i = 0; i < count + 2; i++) begin
         if (i >= 2) begin
            compare_value("fetch_valid_o", 32'(fetch_valid), 32'h1);
            compare_value("fetch_data_o", fetch_data, tbl_exp[first + i - 2]);
         end
         fetch_req = (i < count);
         if (i < count) begin
            fetch_addr = tbl_addr[first + i];
         end
         @(negedge clk);
      end
      compare_value("fetch_valid_o", 32'(fetch_valid), 32'h0);
      end_test(name);
   endtask

   initial begin
      fetch_addr_t err_word;
      fetch_req = 1'b0;
      fetch_addr = '0;
      errors = 0;
      test_errors = 0;
      tests_run = 0;
      tests_failed = 0;
      timed_out = 1'b0;
      void'($urandom(32'hf0da5437));
      build_table();

      wait_reset();
      if (!timed_out) begin
         fill_test();
      end
      if (!timed_out) begin
         for (int i = 0; i < REGION_WORDS; i++) begin
            fetch_once(tbl_addr[i], tbl_exp[i]);
         end
         end_test("single fetches over the region");
         stream_test("back to back fetches", 0, REGION_WORDS);

         // word 9 of the region answered with SLVERR
         err_word = fetch_addr_t'(6'(ERR_OFFSET >> 2));
         compare_value("fill_err_o", 32'(fill_err), 32'h1);
         fetch_once(err_word, expected_word(err_word));
         end_test("error response during the fill");

         stream_test("random addresses", REGION_WORDS, RAND_ENTRIES);
      end

      $display("tests run %0d, failing %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && !timed_out) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== tb_axi_mem.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module tb_axi_mem
   import icache_pkg::*;
(
   input logic clk_i,
   input logic rst_i,
   input axil_ar_t ar_i,
   output logic arready_o,
   output axil_r_t r_o,
   input logic rready_i
);

   localparam logic [`ICACHE_AXI_ADDR_W-1:0] ERR_ADDR = `ICACHE_BASE_ADDR + 16'h0024;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic pending_q;
   logic [`ICACHE_AXI_ADDR_W-1:0] addr_q;

   function automatic word_t mem_word(logic [`ICACHE_AXI_ADDR_W-1:0] a);
      return (32'(a) * 32'h9e3779b1) ^ 32'h5a5a0000;
   endfunction

   // about one cycle in four is a stall
   function automatic logic stall();
      return ($urandom & 32'h3) == 32'h0;
   endfunction

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         arready_o <= 1'b0;
         r_o <= '0;
         pending_q <= 1'b0;
         addr_q <= '0;
      end else begin
         if (arready_o && ar_i.valid) begin
            arready_o <= 1'b0;
            pending_q <= 1'b1;
            addr_q <= ar_i.addr;
         end else if (ar_i.valid && !pending_q && !r_o.valid) begin
            arready_o <= !stall();
         end

         if (r_o.valid) begin
            if (rready_i) begin
               r_o.valid <= 1'b0;
            end
         end else if (pending_q && !stall()) begin
            r_o.valid <= 1'b1;
            r_o.data <= mem_word(addr_q);
            // data still comes back with the error
            r_o.resp <= (addr_q == ERR_ADDR) ? RESP_SLVERR : ICACHE_RESP_OKAY;
            pending_q <= 1'b0;
         end
      end
   end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk_o,
   output logic rst_o
);

   localparam int HALF_PERIOD = 50;
   localparam int RST_CYCLES = 5;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // reset drops on a falling edge, like every other input
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_top
   import icache_pkg::*;
(
   input logic clk_i,
   input logic rst_i,

   // core fetch port
   input logic fetch_req_i,
   input fetch_addr_t fetch_addr_i,
   output word_t fetch_data_o,
   output logic fetch_valid_o,

   // status
   output logic ready_o,
   output logic fill_err_o,

   // AXI4-Lite read master
   output axil_ar_t m_ar_o,
   input logic m_arready_i,
   input axil_r_t m_r_i,
   output logic m_rready_o
);

   fill_wr_t fill;
   logic fill_done;
   offset_t rd_offset;
   word_t [`ICACHE_BLOCKS-1:0] blk_data;

   icache_fill i_fill (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .ar_o(m_ar_o),
      .arready_i(m_arready_i),
      .r_i(m_r_i),
      .rready_o(m_rready_o),
      .fill_o(fill),
      .done_o(fill_done),
      .err_o(fill_err_o)
   );

   // one block per index value
   for (genvar g = 0; g < `ICACHE_BLOCKS; g++) begin : g_blk
      icache_block #(
         .BLOCK_ID(g)
      ) i_block (
         .clk_i(clk_i),
         .fill_i(fill),
         .rd_offset_i(rd_offset),
         .rd_data_o(blk_data[g])
      );
   end

   icache_read i_read (
      .clk_i(clk_i),
      .rst_i(rst_i),
      .ready_i(fill_done),
      .req_i(fetch_req_i),
      .addr_i(fetch_addr_i),
      .blk_offset_o(rd_offset),
      .blk_data_i(blk_data),
      .data_o(fetch_data_o),
      .valid_o(fetch_valid_o)
   );

   assign ready_o = fill_done;

endmodule

// ==== icache_read.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_read
   import icache_pkg::*;
(
   input logic clk_i,
   input logic rst_i,

   input logic ready_i,

   // fetch request from the core
   input logic req_i,
   input fetch_addr_t addr_i,

   // block side
   output offset_t blk_offset_o,
   input word_t [`ICACHE_BLOCKS-1:0] blk_data_i,

   // fetch response
   output word_t data_o,
   output logic valid_o
);

   logic v1_q;
   index_t idx1_q;

   // every block sees the same offset, the index picks one later
   assign blk_offset_o = addr_i.offset;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         v1_q <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         // requests during the fill are dropped here
         v1_q <= req_i && ready_i;
         valid_o <= v1_q;
      end
   end

   // index lines up with the block read latency
   always_ff @(posedge clk_i) begin
      idx1_q <= addr_i.index;
   end

   always_ff @(posedge clk_i) begin
      if (v1_q) begin
         data_o <= blk_data_i[idx1_q];
      end
   end

   a_no_valid_before_ready : assert property (
      @(posedge clk_i) disable iff (rst_i) valid_o |-> ready_i
   ) else $error("fetch valid while the cache is still filling");

endmodule

// ==== icache_fill.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_fill
   import icache_pkg::*;
(
   input logic clk_i,
   input logic rst_i,

   // AXI4-Lite read address channel
   output axil_ar_t ar_o,
   input logic arready_i,

   // AXI4-Lite read data channel
   input axil_r_t r_i,
   output logic rready_o,

   // broadcast to the blocks
   output fill_wr_t fill_o,

   output logic done_o,
   output logic err_o
);

   localparam int CNT_W = `ICACHE_INDEX_W + `ICACHE_OFFSET_W;
   localparam logic [CNT_W-1:0] LAST_WORD = '1;

   typedef enum logic [1:0] {
      S_ADDR,
      S_DATA,
      S_WRITE,
      S_DONE
   } state_t;

   state_t state_q;
   logic [CNT_W-1:0] cnt_q;
   logic arvalid_q;
   logic rready_q;
   logic err_q;
   word_t data_q;
   fetch_addr_t cnt_addr;

   assign cnt_addr = fetch_addr_t'(cnt_q);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= S_ADDR;
         cnt_q <= '0;
         arvalid_q <= 1'b0;
         rready_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         case (state_q)
            S_ADDR: begin
               // first request goes out one cycle after reset release
               if (!arvalid_q) begin
                  arvalid_q <= 1'b1;
               end else if (arready_i) begin
                  arvalid_q <= 1'b0;
                  rready_q <= 1'b1;
                  state_q <= S_DATA;
               end
            end
            S_DATA: begin
               if (r_i.valid) begin
                  rready_q <= 1'b0;
                  state_q <= S_WRITE;
                  // sticky, the word is written anyway
                  if (r_i.resp != ICACHE_RESP_OKAY) begin
                     err_q <= 1'b1;
                  end
               end
            end
            S_WRITE: begin
               if (cnt_q == LAST_WORD) begin
                  state_q <= S_DONE;
               end else begin
                  cnt_q <= cnt_q + 1'b1;
                  arvalid_q <= 1'b1;
                  state_q <= S_ADDR;
               end
            end
            default: begin
               state_q <= S_DONE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (rready_q && r_i.valid) begin
         data_q <= r_i.data;
      end
   end

   assign ar_o.valid = arvalid_q;
   assign ar_o.addr = `ICACHE_BASE_ADDR + (`ICACHE_AXI_ADDR_W'(cnt_q) << 2);
   // unprivileged, secure, instruction access
   assign ar_o.prot = 3'b100;
   assign rready_o = rready_q;

   assign fill_o.valid = (state_q == S_WRITE);
   assign fill_o.index = cnt_addr.index;
   assign fill_o.offset = cnt_addr.offset;
   assign fill_o.data = data_q;

   assign done_o = (state_q == S_DONE);
   assign err_o = err_q;

   a_ar_hold : assert property (
      @(posedge clk_i) disable iff (rst_i)
      ar_o.valid && !arready_i |=> ar_o.valid && $stable(ar_o.addr)
   ) else $error("arvalid dropped or address changed before arready");

   a_done_sticky : assert property (
      @(posedge clk_i) disable iff (rst_i) done_o |=> done_o
   ) else $error("done fell after the fill completed");

endmodule

// ==== icache_block.sv ====
`timescale 1ns/100ps
`include "icache_params.svh"

module icache_block
   import icache_pkg::*;
#(
   parameter int BLOCK_ID = 0
)(
   input logic clk_i,

   // write port, shared by all blocks
   input fill_wr_t fill_i,

   // read port
   input offset_t rd_offset_i,
   output word_t rd_data_o
);

   localparam index_t MY_INDEX = index_t'(BLOCK_ID);

   word_t mem [`ICACHE_WORDS];
   logic wr_en;

   // only the block named by the fill index takes the word
   assign wr_en = fill_i.valid && (fill_i.index == MY_INDEX);

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[fill_i.offset] <= fill_i.data;
      end
   end

   // registered read, one cycle of latency
   always_ff @(posedge clk_i) begin
      rd_data_o <= mem[rd_offset_i];
   end

   // the fill engine must present a known offset with every write
   a_fill_offset_known : assert property (
      @(posedge clk_i) fill_i.valid |-> !$isunknown(fill_i.offset)
   ) else $error("block %0d got a fill with an unknown offset", BLOCK_ID);

endmodule

// ==== icache_pkg.sv ====
`include "icache_params.svh"

package icache_pkg;

   typedef logic [`ICACHE_INDEX_W-1:0] index_t;
   typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;
   typedef logic [`ICACHE_DATA_W-1:0] word_t;

   // word address of a fetch, index above offset
   typedef struct packed {
      index_t index;
      offset_t offset;
   } fetch_addr_t;

   // broadcast write from the fill engine
   typedef struct packed {
      logic valid;
      index_t index;
      offset_t offset;
      word_t data;
   } fill_wr_t;

   // AXI4-Lite read address channel, master to slave
   typedef struct packed {
      logic valid;
      logic [`ICACHE_AXI_ADDR_W-1:0] addr;
      logic [2:0] prot;
   } axil_ar_t;

   // AXI4-Lite read data channel, slave to master
   typedef struct packed {
      logic valid;
      word_t data;
      logic [1:0] resp;
   } axil_r_t;

   localparam logic [1:0] ICACHE_RESP_OKAY = 2'b00;

endpackage

// ==== icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// block select bits of the word address
`define ICACHE_INDEX_W 2

// word select bits inside one block
`define ICACHE_OFFSET_W 4

// derived geometry
`define ICACHE_BLOCKS (1 << `ICACHE_INDEX_W)
`define ICACHE_WORDS (1 << `ICACHE_OFFSET_W)

// instruction word width
`define ICACHE_DATA_W 32

// byte address width on the AXI4-Lite bus
`define ICACHE_AXI_ADDR_W 16

// first cached byte address, tag zero region only
`define ICACHE_BASE_ADDR 16'h0400

`endif
